// File: Makefile
TOP := tb_composite_video

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// File: composite_dac.sv
/*
  composite level encoder
  pixel, blank and sync onto the three resistor-ladder pins
*/

`timescale 1ns/1ps
`default_nettype none

module composite_dac (
  input  wire                         clk_core_12288,
  input  wire                         reset_n,
  input  wire [csync_pkg::pix_w-1:0]  pixel,
  input  wire                         sync,
  input  wire                         blank,
  output logic                        dac_270ohm,
  output logic                        dac_330ohm,
  output logic                        dac_470ohm
);

  import csync_pkg::*;

  logic       sync_d;
  logic       blank_d;
  logic [2:0] level;

  // six brightness steps
  always_comb begin
    if (pixel >= 4'd12) begin
      level = dac_lvl_100;
    end else if (pixel >= 4'd9) begin
      level = dac_lvl_87;
    end else if (pixel >= 4'd6) begin
      level = dac_lvl_76;
    end else if (pixel >= 4'd4) begin
      level = dac_lvl_55;
    end else if (pixel >= 4'd2) begin
      level = dac_lvl_45;
    end else begin
      level = dac_lvl_32;
    end
  end

  always_ff @(posedge clk_core_12288 or negedge reset_n) begin
    if (!reset_n) begin
      sync_d  <= 1'b1;
      blank_d <= 1'b1;
      {dac_270ohm, dac_330ohm, dac_470ohm} <= dac_sync;
    end else begin
      // flags one stage late, matching the store read
      sync_d  <= sync;
      blank_d <= blank;
      if (sync_d) begin
        {dac_270ohm, dac_330ohm, dac_470ohm} <= dac_sync;
      end else if (blank_d) begin
        {dac_270ohm, dac_330ohm, dac_470ohm} <= dac_black;
      end else begin
        {dac_270ohm, dac_330ohm, dac_470ohm} <= level;
      end
    end
  end

  // all three on would exceed the top level
  a_no_overdrive: assert property (
    @(posedge clk_core_12288) disable iff (!reset_n)
    !(dac_270ohm && dac_330ohm && dac_470ohm)
  ) else $error("ladder driven above white level");

endmodule

`default_nettype wire

// File: composite_video_top.sv
/*
  composite monochrome video generator
  frame timing feeds the frame store scan, the ladder encoder
  drives the composite pins, scaler timing runs alongside
*/

`timescale 1ns/1ps
`default_nettype none

module composite_video_top (
  input  wire         clk_core_12288,
  input  wire         reset_n,
  input  wire [31:0]  bridge_addr,
  input  wire         bridge_rd,
  input  wire         bridge_wr,
  input  wire [31:0]  bridge_wr_data,
  output wire [31:0]  bridge_rd_data,
  output wire         dac_270ohm,
  output wire         dac_330ohm,
  output wire         dac_470ohm,
  output wire [23:0]  video_rgb,
  output wire         video_de,
  output wire         video_hs,
  output wire         video_vs
);

  import csync_pkg::*;

  wire coord_t           h_pos;
  wire coord_t           v_pos;
  wire                   sync;
  wire                   blank;
  wire [pix_w-1:0]       pixel;

  //////////////////////////////
  // raster and frame store
  //////////////////////////////

  frame_timing u_timing (
    .clk_core_12288 (clk_core_12288),
    .reset_n        (reset_n),
    .h_pos          (h_pos),
    .v_pos          (v_pos),
    .sync           (sync),
    .blank          (blank)
  );

  // bridge address enters the union port as a plain word
  pixel_store u_store (
    .clk_core_12288 (clk_core_12288),
    .reset_n        (reset_n),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .h_pos          (h_pos),
    .v_pos          (v_pos),
    .pixel          (pixel)
  );

  //////////////////////////////
  // output side
  //////////////////////////////

  composite_dac u_dac (
    .clk_core_12288 (clk_core_12288),
    .reset_n        (reset_n),
    .pixel          (pixel),
    .sync           (sync),
    .blank          (blank),
    .dac_270ohm     (dac_270ohm),
    .dac_330ohm     (dac_330ohm),
    .dac_470ohm     (dac_470ohm)
  );

  scaler_video u_scaler (
    .clk_core_12288 (clk_core_12288),
    .reset_n        (reset_n),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

endmodule

`default_nettype wire

// File: csync_pkg.sv
/*
  composite video shared definitions
  raster timing, frame store geometry, bridge region,
  scaler timing and resistor-ladder output codes
*/

`default_nettype none

package csync_pkg;

  // raster position, wide enough for 780 clocks and 262 lines
  typedef logic [9:0] coord_t;

  //////////////////////////////
  // composite raster
  //////////////////////////////

  localparam coord_t h_total        = 10'd780;
  localparam coord_t v_total        = 10'd262;
  // hsync occupies clocks 0..57
  localparam coord_t h_sync_end     = 10'd58;
  localparam coord_t h_active_start = 10'd144;
  // whole-line vsync on lines 0..2
  localparam coord_t v_sync_end     = 10'd3;
  localparam coord_t v_active_start = 10'd22;

  //////////////////////////////
  // frame store
  //////////////////////////////

  localparam int pix_w     = 4;
  localparam int fb_width  = 256;
  localparam int fb_height = 240;
  // eight pixels per 32-bit word
  localparam int fb_words  = fb_width * fb_height * pix_w / 32;
  localparam int fb_idx_w  = $clog2(fb_words);

  // each pixel is shown for two clocks
  localparam coord_t h_active_end = coord_t'(h_active_start + 2 * fb_width);
  localparam coord_t v_active_end = coord_t'(v_active_start + fb_height);

  // bridge address byte that selects the store
  localparam logic [7:0] fb_region = 8'h10;

  // bridge address, seen whole or as region plus byte offset
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [7:0]  region;
      logic [23:0] offset;
    } fields;
  } bridge_addr_u;

  //////////////////////////////
  // scaler raster
  //////////////////////////////

  localparam int sc_h_total  = 400;
  localparam int sc_v_total  = 512;
  localparam int sc_h_bporch = 10;
  localparam int sc_v_bporch = 10;
  localparam int sc_h_active = 320;
  localparam int sc_v_active = 240;
  // hs lands a few clocks after vs
  localparam int sc_hs_pos   = 3;
  localparam logic [7:0] sc_grey = 8'd60;

  // ladder codes, bit order {270, 330, 470}
  localparam logic [2:0] dac_sync    = 3'b000;
  localparam logic [2:0] dac_black   = 3'b001;
  localparam logic [2:0] dac_lvl_100 = 3'b110;
  localparam logic [2:0] dac_lvl_87  = 3'b101;
  localparam logic [2:0] dac_lvl_76  = 3'b011;
  localparam logic [2:0] dac_lvl_55  = 3'b100;
  localparam logic [2:0] dac_lvl_45  = 3'b010;
  localparam logic [2:0] dac_lvl_32  = 3'b001;

endpackage

`default_nettype wire

// File: flist.f
csync_pkg.sv
frame_timing.sv
pixel_store.sv
composite_dac.sv
scaler_video.sv
composite_video_top.sv
tb_composite_video.sv

// File: frame_timing.sv
/*
  composite frame timing
  780 clocks by 262 lines, registered position,
  composite sync and blank flags
*/

`timescale 1ns/1ps
`default_nettype none

module frame_timing (
  input  wire                clk_core_12288,
  input  wire                reset_n,
  output csync_pkg::coord_t  h_pos,
  output csync_pkg::coord_t  v_pos,
  output logic               sync,
  output logic               blank
);

  import csync_pkg::*;

  coord_t h_next;
  coord_t v_next;
  logic   sync_next;
  logic   blank_next;

  // next raster position, wraps per line and per frame
  always_comb begin
    h_next = h_pos + coord_t'(1);
    v_next = v_pos;
    if (h_pos == h_total - coord_t'(1)) begin
      h_next = '0;
      if (v_pos == v_total - coord_t'(1)) begin
        v_next = '0;
      end else begin
        v_next = v_pos + coord_t'(1);
      end
    end
  end

  // flags decoded from next position so they line up with h_pos and v_pos
  always_comb begin
    sync_next  = (h_next < h_sync_end) || (v_next < v_sync_end);
    blank_next = (h_next < h_active_start) || (h_next >= h_active_end) ||
                 (v_next < v_active_start) || (v_next >= v_active_end);
  end

  // (0,0) sits inside both windows
  always_ff @(posedge clk_core_12288 or negedge reset_n) begin
    if (!reset_n) begin
      h_pos <= '0;
      v_pos <= '0;
      sync  <= 1'b1;
      blank <= 1'b1;
    end else begin
      h_pos <= h_next;
      v_pos <= v_next;
      sync  <= sync_next;
      blank <= blank_next;
    end
  end

  // sync level only ever inside the blank window
  a_sync_in_blank: assert property (
    @(posedge clk_core_12288) disable iff (!reset_n) sync |-> blank
  ) else $error("composite sync outside blank");

endmodule

`default_nettype wire

// File: pixel_store.sv
/*
  4 bpp frame store, 256 x 240 pixels in 32-bit words
  bridge port for word writes and reads,
  scan port returning one pixel per clock
*/

`timescale 1ns/1ps
`default_nettype none

module pixel_store (
  input  wire                          clk_core_12288,
  input  wire                          reset_n,
  input  wire csync_pkg::bridge_addr_u bridge_addr,
  input  wire                          bridge_rd,
  input  wire                          bridge_wr,
  input  wire [31:0]                   bridge_wr_data,
  output logic [31:0]                  bridge_rd_data,
  input  wire csync_pkg::coord_t       h_pos,
  input  wire csync_pkg::coord_t       v_pos,
  output logic [csync_pkg::pix_w-1:0]  pixel
);

  import csync_pkg::*;

  logic [31:0] mem [fb_words];

  logic                region_hit;
  logic [13:0]         bridge_idx;
  logic                bridge_ok;
  logic                wr_en;

  coord_t              h_rel;
  coord_t              v_rel;
  logic [7:0]          col;
  logic [7:0]          row;
  logic                in_store;
  logic [fb_idx_w-1:0] scan_idx;
  logic [2:0]          nib_sel;
  logic [31:0]         scan_word;

  //////////////////////////////
  // bridge side
  //////////////////////////////

  // region byte from the field view, word index from raw bits 15:2
  assign region_hit = (bridge_addr.fields.region == fb_region);
  assign bridge_idx = bridge_addr.raw[15:2];
  assign bridge_ok  = region_hit && (bridge_idx < 14'(fb_words));
  assign wr_en      = bridge_wr && bridge_ok;

  always_ff @(posedge clk_core_12288) begin
    if (wr_en) begin
      mem[bridge_idx[fb_idx_w-1:0]] <= bridge_wr_data;
    end
  end

  // read data held until the next read strobe
  always_ff @(posedge clk_core_12288 or negedge reset_n) begin
    if (!reset_n) begin
      bridge_rd_data <= '0;
    end else if (bridge_rd) begin
      bridge_rd_data <= bridge_ok ? mem[bridge_idx[fb_idx_w-1:0]] : '0;
    end
  end

  //////////////////////////////
  // scan side
  //////////////////////////////

  // two clocks per pixel, so drop bit 0 of the offset
  assign h_rel    = h_pos - h_active_start;
  assign v_rel    = v_pos - v_active_start;
  assign col      = h_rel[8:1];
  assign row      = v_rel[7:0];
  assign in_store = (h_pos >= h_active_start) && (h_pos < h_active_end) &&
                    (v_pos >= v_active_start) && (v_pos < v_active_end);

  // word = row * 32 + col / 8
  assign scan_idx  = {row, col[7:3]};
  assign nib_sel   = col[2:0];
  assign scan_word = mem[scan_idx];

  // lowest x in the top nibble
  always_ff @(posedge clk_core_12288) begin
    pixel <= in_store ? scan_word[(7 - nib_sel) * pix_w +: pix_w] : '0;
  end

  a_rd_wr_excl: assert property (
    @(posedge clk_core_12288) disable iff (!reset_n) !(bridge_rd && bridge_wr)
  ) else $error("bridge read and write strobes together");

endmodule

`default_nettype wire

// File: scaler_video.sv
/*
  scaler video timing
  400 x 512 raster with a 320 x 240 grey active area
*/

`timescale 1ns/1ps
`default_nettype none

module scaler_video (
  input  wire          clk_core_12288,
  input  wire          reset_n,
  output logic [23:0]  video_rgb,
  output logic         video_de,
  output logic         video_hs,
  output logic         video_vs
);

  import csync_pkg::*;

  logic [9:0] x_cnt;
  logic [9:0] y_cnt;
  logic       in_window;

  // active area after the back porch on both axes
  assign in_window = (x_cnt >= sc_h_bporch) && (x_cnt < sc_h_bporch + sc_h_active) &&
                     (y_cnt >= sc_v_bporch) && (y_cnt < sc_v_bporch + sc_v_active);

  always_ff @(posedge clk_core_12288 or negedge reset_n) begin
    if (!reset_n) begin
      x_cnt     <= '0;
      y_cnt     <= '0;
      video_vs  <= 1'b0;
      video_hs  <= 1'b0;
      video_de  <= 1'b0;
      video_rgb <= '0;
    end else begin
      // line and frame counters
      if (x_cnt == sc_h_total - 1) begin
        x_cnt <= '0;
        if (y_cnt == sc_v_total - 1) begin
          y_cnt <= '0;
        end else begin
          y_cnt <= y_cnt + 10'd1;
        end
      end else begin
        x_cnt <= x_cnt + 10'd1;
      end

      // single-clock pulses, new frame then new line
      video_vs <= (x_cnt == '0) && (y_cnt == '0);
      video_hs <= (x_cnt == sc_hs_pos);

      // grey inside, black in the border
      video_de  <= in_window;
      video_rgb <= in_window ? {3{sc_grey}} : 24'h0;
    end
  end

  // hs pulse sits in the porch, clear of data enable
  a_hs_outside_de: assert property (
    @(posedge clk_core_12288) disable iff (!reset_n) !(video_de && video_hs)
  ) else $error("scaler hs during data enable");

endmodule

`default_nettype wire

// File: tb_composite_video.sv
/*
  testbench for the composite video generator
  directed checks of reset, bridge access, composite sync
  and brightness levels, and the scaler raster
*/

`timescale 1ns/1ps
`default_nettype none

module tb_composite_video;

  import csync_pkg::*;

  localparam int comp_frame = int'(h_total) * int'(v_total);
  localparam int sc_frame   = sc_h_total * sc_v_total;
  // reset and bridge ~50, two composite frames 408720, fill 7680,
  // scaler frame 204800, about 621k in all
  localparam int max_cycles = 700000;

  logic        clk_core_12288;
  logic        reset_n;
  logic [31:0] bridge_addr;
  logic        bridge_rd;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  wire  [31:0] bridge_rd_data;
  wire         dac_270ohm;
  wire         dac_330ohm;
  wire         dac_470ohm;
  wire  [23:0] video_rgb;
  wire         video_de;
  wire         video_hs;
  wire         video_vs;
  wire  [2:0]  dac_pins;

  // words as written over the bridge
  logic [31:0] shadow [fb_words];
  logic [31:0] lfsr_state;
  int          cyc;
  int          comp_h;
  int          comp_v;
  int          sc_x;
  int          sc_y;
  int          tmo_cnt = 0;

  assign dac_pins = {dac_270ohm, dac_330ohm, dac_470ohm};

  composite_video_top u_dut (
    .clk_core_12288 (clk_core_12288),
    .reset_n        (reset_n),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .dac_270ohm     (dac_270ohm),
    .dac_330ohm     (dac_330ohm),
    .dac_470ohm     (dac_470ohm),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

  //////////////////////////////
  // clock, reference raster, timeout
  //////////////////////////////

  initial begin
    clk_core_12288 = 1'b0;
    forever #20 clk_core_12288 = ~clk_core_12288;
  end

  // position on the pins, dac two clocks behind, scaler one clock
  always @(posedge clk_core_12288) begin
    if (!reset_n) begin
      cyc    <= 0;
      comp_h <= 0;
      comp_v <= 0;
      sc_x   <= 0;
      sc_y   <= 0;
    end else begin
      cyc <= cyc + 1;
      if (cyc >= 2) begin
        comp_h <= (comp_h == int'(h_total) - 1) ? 0 : comp_h + 1;
        if (comp_h == int'(h_total) - 1) begin
          comp_v <= (comp_v == int'(v_total) - 1) ? 0 : comp_v + 1;
        end
      end
      if (cyc >= 1) begin
        sc_x <= (sc_x == sc_h_total - 1) ? 0 : sc_x + 1;
        if (sc_x == sc_h_total - 1) begin
          sc_y <= (sc_y == sc_v_total - 1) ? 0 : sc_y + 1;
        end
      end
    end
  end

  always @(posedge clk_core_12288) begin
    tmo_cnt <= tmo_cnt + 1;
    if (tmo_cnt >= max_cycles) begin
      fail_run($sformatf("timeout, run exceeded %0d clock cycles", max_cycles));
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  // next clock edge plus the drive delay
  task automatic step();
    @(posedge clk_core_12288);
    #2;
  endtask

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    int          b;
    w = '0;
    for (b = 0; b < 32; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic logic [31:0] make_addr(input logic [7:0] region, input int idx);
    bridge_addr_u a;
    a.raw           = '0;
    a.fields.region = region;
    a.fields.offset = 24'(idx * 4);
    return a.raw;
  endfunction

  // six-step brightness table
  function automatic logic [2:0] level_code(input logic [3:0] pix);
    logic [2:0] code;
    if (pix >= 4'd12) code = 3'b110;
    else if (pix >= 4'd9) code = 3'b101;
    else if (pix >= 4'd6) code = 3'b011;
    else if (pix >= 4'd4) code = 3'b100;
    else if (pix >= 4'd2) code = 3'b010;
    else code = 3'b001;
    return code;
  endfunction

  function automatic logic is_blank(input int h, input int v);
    return (h < int'(h_active_start)) || (h >= int'(h_active_start) + 2 * fb_width) ||
           (v < int'(v_active_start));
  endfunction

  // expected pins for a raster position, pixel from the shadow store
  function automatic logic [2:0] expected_dac(input int h, input int v);
    int          col;
    int          row;
    logic [31:0] w;
    logic [2:0]  code;
    if ((h < int'(h_sync_end)) || (v < int'(v_sync_end))) begin
      code = 3'b000;
    end else if (is_blank(h, v)) begin
      code = 3'b001;
    end else begin
      col  = (h - int'(h_active_start)) / 2;
      row  = v - int'(v_active_start);
      w    = shadow[row * 32 + col / 8];
      // lowest x in bits 31:28
      code = level_code(w[31 - 4 * (col % 8) -: 4]);
    end
    return code;
  endfunction

  task automatic bridge_write(input logic [7:0] region, input int idx,
                              input logic [31:0] data);
    bridge_addr    = make_addr(region, idx);
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    step();
    bridge_wr      = 1'b0;
  endtask

  // data is valid one clock after the strobe
  task automatic check_read(input logic [7:0] region, input int idx,
                            input logic [31:0] exp, input string label);
    bridge_addr = make_addr(region, idx);
    bridge_rd   = 1'b1;
    step();
    bridge_rd   = 1'b0;
    assert (bridge_rd_data == exp) else fail_run($sformatf(
      "mismatch bridge_rd_data %s expected %h got %h", label, exp, bridge_rd_data));
  endtask

  task automatic check_idle(input string label);
    assert (dac_pins == 3'b000) else fail_run($sformatf(
      "mismatch dac_270ohm/330ohm/470ohm %s expected %h got %h", label, 3'b000, dac_pins));
    assert (video_de == 1'b0) else fail_run($sformatf(
      "mismatch video_de %s expected %h got %h", label, 1'b0, video_de));
    assert (video_hs == 1'b0) else fail_run($sformatf(
      "mismatch video_hs %s expected %h got %h", label, 1'b0, video_hs));
    assert (video_vs == 1'b0) else fail_run($sformatf(
      "mismatch video_vs %s expected %h got %h", label, 1'b0, video_vs));
    assert (bridge_rd_data == 32'h0) else fail_run($sformatf(
      "mismatch bridge_rd_data %s expected %h got %h", label, 32'h0, bridge_rd_data));
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic check_reset();
    int i;
    reset_n = 1'b0;
    for (i = 0; i < 16; i++) begin
      step();
      check_idle("during reset");
    end
    reset_n = 1'b1;
    // still the reset state when the first edge arrives
    check_idle("at first edge after release");
  endtask

  task automatic check_bridge();
    logic [31:0] first_word;
    logic [31:0] last_word;
    first_word = rand_word();
    last_word  = rand_word();
    bridge_write(fb_region, 0, first_word);
    bridge_write(fb_region, fb_words - 1, last_word);
    shadow[0]            = first_word;
    shadow[fb_words - 1] = last_word;
    check_read(fb_region, 0, first_word, "first word");
    check_read(fb_region, fb_words - 1, last_word, "last word");
    // zero even right after a nonzero read
    check_read(8'h20, 0, 32'h0, "foreign region read");
    bridge_write(8'h20, 0, rand_word());
    check_read(fb_region, 0, first_word, "word 0 after foreign write");
    // one past the last word
    bridge_write(fb_region, fb_words, rand_word());
    check_read(fb_region, fb_words, 32'h0, "index past the store");
    check_read(fb_region, fb_words - 1, last_word, "last word after overrun write");
  endtask

  task automatic check_sync_blank();
    int n;
    for (n = 0; n < comp_frame; n++) begin
      step();
      if (is_blank(comp_h, comp_v)) begin
        assert (dac_pins == expected_dac(comp_h, comp_v)) else fail_run($sformatf(
          "mismatch dac_270ohm/330ohm/470ohm blank h %0d v %0d expected %h got %h",
          comp_h, comp_v, expected_dac(comp_h, comp_v), dac_pins));
      end
    end
  endtask

  task automatic check_active_levels();
    logic [31:0] w;
    int          i;
    int          n;
    for (i = 0; i < fb_words; i++) begin
      w         = rand_word();
      shadow[i] = w;
      bridge_write(fb_region, i, w);
    end
    // let the last write pass the scan read
    step();
    step();
    for (n = 0; n < comp_frame; n++) begin
      step();
      assert (dac_pins == expected_dac(comp_h, comp_v)) else fail_run($sformatf(
        "mismatch dac_270ohm/330ohm/470ohm h %0d v %0d expected %h got %h",
        comp_h, comp_v, expected_dac(comp_h, comp_v), dac_pins));
    end
  endtask

  task automatic check_scaler();
    int          vs_seen;
    int          hs_seen;
    int          de_cnt [sc_v_total];
    int          de_min [sc_v_total];
    logic        exp_de;
    logic [23:0] exp_rgb;
    int          n;
    int          y;
    vs_seen = 0;
    hs_seen = 0;
    for (y = 0; y < sc_v_total; y++) begin
      de_cnt[y] = 0;
      de_min[y] = 1023;
    end
    for (n = 0; n < sc_frame; n++) begin
      step();
      exp_de  = (sc_x >= sc_h_bporch) && (sc_x < sc_h_bporch + sc_h_active) &&
                (sc_y >= sc_v_bporch) && (sc_y < sc_v_bporch + sc_v_active);
      exp_rgb = exp_de ? {3{sc_grey}} : 24'h0;
      assert (video_de == exp_de) else fail_run($sformatf(
        "mismatch video_de x %0d y %0d expected %h got %h", sc_x, sc_y, exp_de, video_de));
      assert (video_rgb == exp_rgb) else fail_run($sformatf(
        "mismatch video_rgb x %0d y %0d expected %h got %h", sc_x, sc_y, exp_rgb, video_rgb));
      if (video_vs) begin
        vs_seen++;
        assert ((sc_x == 0) && (sc_y == 0)) else fail_run("video_vs pulsed away from frame start");
      end
      if (video_hs) begin
        hs_seen++;
        assert (sc_x == sc_hs_pos) else fail_run("video_hs pulsed at the wrong line position");
      end
      if (video_de) begin
        de_cnt[sc_y]++;
        if (sc_x < de_min[sc_y]) de_min[sc_y] = sc_x;
      end
    end
    assert (vs_seen == 1) else fail_run($sformatf(
      "mismatch video_vs pulse count expected %h got %h", 1, vs_seen));
    assert (hs_seen == sc_v_total) else fail_run($sformatf(
      "mismatch video_hs pulse count expected %h got %h", sc_v_total, hs_seen));
    for (y = sc_v_bporch; y < sc_v_bporch + sc_v_active; y++) begin
      assert (de_cnt[y] == sc_h_active) else fail_run($sformatf(
        "mismatch video_de count line %0d expected %h got %h", y, sc_h_active, de_cnt[y]));
      assert (de_min[y] == sc_h_bporch) else fail_run($sformatf(
        "mismatch video_de start line %0d expected %h got %h", y, sc_h_bporch, de_min[y]));
    end
  endtask

  initial begin
    reset_n        = 1'b0;
    bridge_addr    = '0;
    bridge_rd      = 1'b0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    lfsr_state     = 32'hbc81;
    check_reset();
    check_bridge();
    check_sync_blank();
    check_active_levels();
    check_scaler();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire
